//--- Bender.yml
package:
  name: pcs_loopback

sources:
  - include_dirs:
      - src
    files:
      - src/pcs_block_pkg.sv
      - src/pcs_ctrl_pkg.sv
      - src/gx_reset_seq.sv
      - src/pcs_scrambler.sv
      - src/pcs_block_lock.sv
      - src/pcs_loopback_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/pcs_loopback_sva.sv
      - testbench/pcs_loopback_tb.sv

//--- list.f
+incdir+src
src/pcs_block_pkg.sv
src/pcs_ctrl_pkg.sv
src/gx_reset_seq.sv
src/pcs_scrambler.sv
src/pcs_block_lock.sv
src/pcs_loopback_top.sv
testbench/pcs_loopback_sva.sv
testbench/pcs_loopback_tb.sv

//--- src/gx_reset_seq.sv
////////////////////////////////////////////////////////////
// Transceiver reset sequencer
// Releases tx analog, tx digital, rx analog and rx digital
// resets in order, gated by calibration and CDR lock status.
// rx_ready_o is high only in READY; CDR loss restarts the
// receive digital side without touching the transmit side.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "pcs_settings.svh"

module gx_reset_seq (
	input  logic clk_i,
	input  logic rst_n_i,                // sync, active low
	input  logic tx_cal_busy_i,
	input  logic rx_cal_busy_i,
	input  logic rx_is_lockedtodata_i,   // cdr locked to incoming data
	output logic tx_analogreset_o,
	output logic tx_digitalreset_o,
	output logic rx_analogreset_o,
	output logic rx_digitalreset_o,
	output logic rx_ready_o
);
	import pcs_ctrl_pkg::*;

	localparam int HOLD_W = $clog2(`PCS_RST_HOLD + 1);

	rst_state_t        state_q;
	logic [HOLD_W-1:0] hold_cnt_q;   // cycles spent in current hold step
	logic              hold_done;
	logic              tx_ana_q;
	logic              tx_dig_q;
	logic              rx_ana_q;
	logic              rx_dig_q;

	assign hold_done = (hold_cnt_q == HOLD_W'(`PCS_RST_HOLD - 1));

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state_q    <= RST_ALL;
			hold_cnt_q <= '0;
			tx_ana_q   <= 1'b1;     // all four resets asserted
			tx_dig_q   <= 1'b1;
			rx_ana_q   <= 1'b1;
			rx_dig_q   <= 1'b1;
		end else begin
			hold_cnt_q <= hold_cnt_q + HOLD_W'(1);   // default, cleared below on each step
			case (state_q)
			RST_ALL: if (hold_done) begin
				state_q    <= WAIT_CAL;
				hold_cnt_q <= '0;
			end
			WAIT_CAL: begin
				hold_cnt_q <= '0;
				if (!tx_cal_busy_i && !rx_cal_busy_i)   // both idle on the same cycle
					state_q <= TX_ANA;
			end
			TX_ANA: if (hold_done) begin
				tx_ana_q   <= 1'b0;
				state_q    <= TX_DIG;
				hold_cnt_q <= '0;
			end
			TX_DIG: if (hold_done) begin
				tx_dig_q   <= 1'b0;
				state_q    <= RX_CDR;
				hold_cnt_q <= '0;
			end
			RX_CDR: begin
				if (rx_ana_q) begin   // first pass, rx analog still held
					if (hold_done) begin
						rx_ana_q   <= 1'b0;
						hold_cnt_q <= '0;
					end
				end else begin
					hold_cnt_q <= '0;   // idle while cdr settles
					if (rx_is_lockedtodata_i)
						state_q <= RX_DIG;
				end
			end
			RX_DIG: begin
				if (!rx_is_lockedtodata_i) begin   // lost it again before release
					state_q    <= RX_CDR;
					hold_cnt_q <= '0;
				end else if (hold_done) begin
					rx_dig_q <= 1'b0;
					state_q  <= READY;
				end
			end
			READY: begin
				hold_cnt_q <= '0;
				if (!rx_is_lockedtodata_i) begin   // cdr loss, rx digital only
					rx_dig_q <= 1'b1;
					state_q  <= RX_CDR;
				end
			end
			default: state_q <= RST_ALL;
			endcase
		end
	end

	assign tx_analogreset_o  = tx_ana_q;
	assign tx_digitalreset_o = tx_dig_q;
	assign rx_analogreset_o  = rx_ana_q;
	assign rx_digitalreset_o = rx_dig_q;
	assign rx_ready_o        = (state_q == READY);

endmodule

//--- src/pcs_block_lock.sv
////////////////////////////////////////////////////////////
// Sync header checker with block lock state machine
// Gains lock after a run of good headers, loses it on too
// many bad headers inside one window of valid blocks.
// Held in HUNT while enable_i is low.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "pcs_settings.svh"

module pcs_block_lock (
	input  logic                      clk_i,
	input  logic                      rst_n_i,    // sync, active low
	input  logic                      enable_i,   // receive side out of reset
	input  logic                      valid_i,
	input  pcs_block_pkg::sync_head_t head_i,
	output logic                      lock_o
);
	import pcs_block_pkg::*;
	import pcs_ctrl_pkg::*;

	lock_state_t state_q;
	lock_cnt_t   blk_cnt_q;   // good run in HUNT/TEST, window position in LOCKED
	lock_cnt_t   bad_cnt_q;   // bad headers in current window
	logic        head_ok;

	assign head_ok = (head_i == HEAD_DATA) || (head_i == HEAD_CTRL);

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state_q   <= HUNT;
			blk_cnt_q <= '0;
			bad_cnt_q <= '0;
		end else if (!enable_i) begin   // rx digital still in reset
			state_q   <= HUNT;
			blk_cnt_q <= '0;
			bad_cnt_q <= '0;
		end else if (valid_i) begin
			case (state_q)
			HUNT, TEST: begin
				if (!head_ok) begin   // restart the run
					state_q   <= HUNT;
					blk_cnt_q <= '0;
				end else if (blk_cnt_q == lock_cnt_t'(`PCS_LOCK_GOOD - 1)) begin
					state_q   <= LOCKED;
					blk_cnt_q <= '0;
					bad_cnt_q <= '0;
				end else begin
					state_q   <= TEST;
					blk_cnt_q <= blk_cnt_q + 1'b1;
				end
			end
			LOCKED: begin
				if (!head_ok && (bad_cnt_q == lock_cnt_t'(`PCS_LOCK_BAD - 1))) begin
					state_q   <= HUNT;   // too many in this window
					blk_cnt_q <= '0;
					bad_cnt_q <= '0;
				end else if (blk_cnt_q == lock_cnt_t'(`PCS_LOCK_WIN - 1)) begin
					blk_cnt_q <= '0;     // window closed, start fresh
					bad_cnt_q <= '0;
				end else begin
					blk_cnt_q <= blk_cnt_q + 1'b1;
					if (!head_ok)
						bad_cnt_q <= bad_cnt_q + 1'b1;
				end
			end
			default: state_q <= HUNT;
			endcase
		end
	end

	// enable drops on the same cycle rx digital reset rises
	assign lock_o = enable_i && (state_q == LOCKED);

endmodule

//--- src/pcs_block_pkg.sv
////////////////////////////////////////////////////////////
// Data types of the 66-bit block datapath
// Sync headers, payloads, scrambler state and lock counters.
// Module headers use the scoped names, bodies import it.
////////////////////////////////////////////////////////////
`include "pcs_settings.svh"

package pcs_block_pkg;

	typedef logic [`PCS_HEAD_W-1:0] sync_head_t;   // 01 data, 10 control, else invalid
	typedef logic [`PCS_DATA_W-1:0] blk_data_t;    // bit 0 goes on the line first
	typedef logic [57:0]            scr_state_t;   // x^58 + x^39 + 1 delay line
	typedef logic [6:0]             lock_cnt_t;    // up to 127, covers 64-block windows

	// valid sync header codes
	localparam sync_head_t HEAD_DATA = 2'b01;     // all 8 octets are data
	localparam sync_head_t HEAD_CTRL = 2'b10;     // block type byte follows

endpackage

//--- src/pcs_ctrl_pkg.sv
////////////////////////////////////////////////////////////
// Control state types of the PCS loopback
// FSM encodings for the transceiver reset sequencer and
// the block lock checker.
////////////////////////////////////////////////////////////
package pcs_ctrl_pkg;

	// transceiver reset sequencer
	typedef enum logic [2:0] {
		RST_ALL,    // every reset held high
		WAIT_CAL,   // wait for both calibrations to finish
		TX_ANA,     // hold, then release tx analog
		TX_DIG,     // hold, then release tx digital
		RX_CDR,     // release rx analog, wait for cdr lock
		RX_DIG,     // hold, then release rx digital
		READY       // receive side usable
	} rst_state_t;

	// block lock fsm
	typedef enum logic [1:0] {
		HUNT,       // looking for a first good header
		TEST,       // counting a run of good headers
		LOCKED      // locked, watching bad headers per window
	} lock_state_t;

endpackage

//--- src/pcs_loopback_top.sv
////////////////////////////////////////////////////////////
// 10GBASE-R PCS loopback for one transceiver channel
// Receive blocks are descrambled and lock-checked, then
// rescrambled onto the transmit side. Idle control blocks
// are sent while block lock is missing. Latency is 2 cycles.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "pcs_settings.svh"

module pcs_loopback_top (
	input  logic                      OSC_50m,
	input  logic                      rst_n_i,        // sync, active low, from board
	input  logic                      gx_tx_cal_busy_i,
	input  logic                      gx_rx_cal_busy_i,
	input  logic                      gx_rx_is_lockedtodata_i,
	output logic                      gx_tx_analogreset_o,
	output logic                      gx_tx_digitalreset_o,
	output logic                      gx_rx_analogreset_o,
	output logic                      gx_rx_digitalreset_o,
	input  logic                      rx_valid_i,     // one aligned block per strobe
	input  pcs_block_pkg::sync_head_t rx_head_i,
	input  pcs_block_pkg::blk_data_t  rx_data_i,
	output logic                      tx_valid_o,
	output pcs_block_pkg::sync_head_t tx_head_o,
	output pcs_block_pkg::blk_data_t  tx_data_o,
	output logic                      link_ready_o,
	output logic                      block_lock_o
);
	import pcs_block_pkg::*;

	logic       rst_meta_q;
	logic       rst_sync_n;   // 2ff synced reset, used by all logic below
	logic       rx_ready;
	logic       desc_valid;
	sync_head_t desc_head;
	blk_data_t  desc_data;
	logic       block_lock;
	sync_head_t mux_head;
	blk_data_t  mux_data;

	always_ff @(posedge OSC_50m) begin
		rst_meta_q <= rst_n_i;
		rst_sync_n <= rst_meta_q;
	end

	gx_reset_seq gx_reset_seq_inst (
		.clk_i               (OSC_50m),
		.rst_n_i             (rst_sync_n),
		.tx_cal_busy_i       (gx_tx_cal_busy_i),
		.rx_cal_busy_i       (gx_rx_cal_busy_i),
		.rx_is_lockedtodata_i(gx_rx_is_lockedtodata_i),
		.tx_analogreset_o    (gx_tx_analogreset_o),
		.tx_digitalreset_o   (gx_tx_digitalreset_o),
		.rx_analogreset_o    (gx_rx_analogreset_o),
		.rx_digitalreset_o   (gx_rx_digitalreset_o),
		.rx_ready_o          (rx_ready)
	);

	pcs_scrambler #(.DESCRAMBLE(1'b1)) rx_descrambler_inst (
		.clk_i  (OSC_50m),
		.rst_n_i(rst_sync_n),
		.valid_i(rx_valid_i),
		.head_i (rx_head_i),
		.data_i (rx_data_i),
		.valid_o(desc_valid),
		.head_o (desc_head),
		.data_o (desc_data)
	);

	pcs_block_lock pcs_block_lock_inst (
		.clk_i   (OSC_50m),
		.rst_n_i (rst_sync_n),
		.enable_i(rx_ready),
		.valid_i (desc_valid),
		.head_i  (desc_head),
		.lock_o  (block_lock)
	);

	// loop back only when locked, otherwise idle control blocks
	assign mux_head = block_lock ? desc_head : HEAD_CTRL;
	assign mux_data = block_lock ? desc_data : blk_data_t'(`PCS_IDLE_DATA);

	pcs_scrambler #(.DESCRAMBLE(1'b0)) tx_scrambler_inst (
		.clk_i  (OSC_50m),
		.rst_n_i(rst_sync_n),
		.valid_i(desc_valid),   // strobe follows the data, lock or not
		.head_i (mux_head),
		.data_i (mux_data),
		.valid_o(tx_valid_o),
		.head_o (tx_head_o),
		.data_o (tx_data_o)
	);

	assign block_lock_o = block_lock;
	assign link_ready_o = rx_ready && block_lock;

endmodule

//--- src/pcs_scrambler.sv
////////////////////////////////////////////////////////////
// Self-synchronizing 10GBASE-R scrambler, x^58 + x^39 + 1
// DESCRAMBLE=0 scrambles, DESCRAMBLE=1 descrambles. Only
// the payload is touched; the sync header is delayed along.
// One cycle latency, state advances on valid blocks only.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module pcs_scrambler #(
	parameter bit DESCRAMBLE = 1'b0   // 1: feed the state from the input bits
) (
	input  logic                      clk_i,
	input  logic                      rst_n_i,   // sync, active low
	input  logic                      valid_i,
	input  pcs_block_pkg::sync_head_t head_i,
	input  pcs_block_pkg::blk_data_t  data_i,
	output logic                      valid_o,
	output pcs_block_pkg::sync_head_t head_o,
	output pcs_block_pkg::blk_data_t  data_o
);
	import pcs_block_pkg::*;

	scr_state_t state_q;     // bit 0 is the newest line bit
	scr_state_t state_nxt;
	blk_data_t  data_nxt;

	// bit-serial unroll over the block, bit 0 first
	always_comb begin
		scr_state_t st;
		logic       fb;
		st = state_q;
		for (int i = 0; i < $bits(blk_data_t); i++) begin
			fb          = st[38] ^ st[57];   // taps at delay 39 and 58
			data_nxt[i] = data_i[i] ^ fb;
			st          = {st[56:0], (DESCRAMBLE ? data_i[i] : data_nxt[i])};   // line bit in
		end
		state_nxt = st;
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			valid_o <= 1'b0;
			state_q <= '0;
		end else begin
			valid_o <= valid_i;
			if (valid_i)
				state_q <= state_nxt;   // no advance on gaps
		end
	end

	always_ff @(posedge clk_i) begin
		if (valid_i) begin
			head_o <= head_i;     // header never scrambled
			data_o <= data_nxt;
		end
	end

endmodule

//--- src/pcs_settings.svh
////////////////////////////////////////////////////////////
// Shared constants for the 10GBASE-R PCS loopback
// Reset sequencing delays, block lock thresholds and the
// idle control block. Include wherever a constant is needed.
////////////////////////////////////////////////////////////
`ifndef PCS_SETTINGS_SVH
`define PCS_SETTINGS_SVH

// block geometry
`define PCS_DATA_W 64          // payload bits per 66-bit block
`define PCS_HEAD_W 2           // sync header bits

// transceiver reset sequencing
`define PCS_RST_HOLD 16        // cycles each reset step is held

// block lock, per 802.3 clause 49 style lock fsm
`define PCS_LOCK_GOOD 64       // consecutive good headers to lock
`define PCS_LOCK_WIN 64        // blocks per bad-header window
`define PCS_LOCK_BAD 16        // bad headers per window that drop lock

// idle control block, type 0x1e in the low byte, all 8 control codes zero
`define PCS_IDLE_DATA 64'h0000_0000_0000_001E

`endif

//--- testbench/pcs_loopback_sva.sv
////////////////////////////////////////////////////////////
// Concurrent assertions for the PCS loopback top
// Bound into the top; checks reset ordering, the fixed
// two cycle valid latency and lock held low in rx reset.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module pcs_loopback_sva (
	input logic clk_i,
	input logic rst_n_i,
	input logic tx_ana_rst_i,
	input logic tx_dig_rst_i,
	input logic rx_ana_rst_i,
	input logic rx_dig_rst_i,
	input logic rx_valid_i,
	input logic tx_valid_i,
	input logic block_lock_i
);

	int unsigned fail_cnt = 0;   // assertion failures seen so far

	// digital side only leaves reset after its analog side
	reset_order: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(!tx_dig_rst_i |-> !tx_ana_rst_i) and (!rx_dig_rst_i |-> !rx_ana_rst_i))
		else begin
			$error("digital reset released while its analog reset is held");
			fail_cnt++;
		end

	valid_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		tx_valid_i == $past(rx_valid_i, 2))   // descrambler plus scrambler
		else begin
			$error("tx valid does not follow rx valid by two cycles");
			fail_cnt++;
		end

	lock_in_reset: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		rx_dig_rst_i |-> !block_lock_i)
		else begin
			$error("block lock high while rx digital reset is asserted");
			fail_cnt++;
		end

endmodule

bind pcs_loopback_top pcs_loopback_sva pcs_loopback_sva_inst (
	.clk_i       (OSC_50m),
	.rst_n_i     (rst_n_i),
	.tx_ana_rst_i(gx_tx_analogreset_o),
	.tx_dig_rst_i(gx_tx_digitalreset_o),
	.rx_ana_rst_i(gx_rx_analogreset_o),
	.rx_dig_rst_i(gx_rx_digitalreset_o),
	.rx_valid_i  (rx_valid_i),
	.tx_valid_i  (tx_valid_o),
	.block_lock_i(block_lock_o)
);

//--- testbench/pcs_loopback_tb.sv
////////////////////////////////////////////////////////////
// Testbench for the 10GBASE-R PCS loopback
// Directed tests of reset sequencing, idle substitution,
// block lock gain and loss, data loopback and CDR loss.
// Reference scrambler models encode the stimulus and decode
// the DUT output; one line per test, then a summary line.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "pcs_settings.svh"

module pcs_loopback_tb;
	import pcs_block_pkg::*;

	localparam int TIMEOUT = 500;   // cycles allowed for any wait loop

	logic        OSC_50m, rst_n_i;
	logic        gx_tx_cal_busy_i, gx_rx_cal_busy_i, gx_rx_is_lockedtodata_i;
	logic        gx_tx_analogreset_o, gx_tx_digitalreset_o;
	logic        gx_rx_analogreset_o, gx_rx_digitalreset_o;
	logic        rx_valid_i, tx_valid_o, link_ready_o, block_lock_o;
	sync_head_t  rx_head_i, tx_head_o;
	blk_data_t   rx_data_i, tx_data_o;

	sync_head_t  exp_head_q[$];   // expected tx blocks in send order
	blk_data_t   exp_data_q[$];
	logic [57:0] tx_hist;         // line history of the stimulus scrambler
	logic [57:0] out_hist;        // line history of the output descrambler
	logic [1:0]  vld_pipe;        // rx_valid_i of the last two cycles
	bit          out_seen;        // first tx block only seeds out_hist
	int          win_pos;         // window slot of the next valid block
	int          errors, tests, failed;

	pcs_loopback_top pcs_loopback_top_inst (.*);

	always #10 OSC_50m = ~OSC_50m;   // 50 MHz

	// x^58 + x^39 + 1 over the line bits in send order
	// line[57:0] holds the history with the oldest bit at 0
	function automatic blk_data_t line_code(input blk_data_t din, inout logic [57:0] hist,
			input bit desc);
		logic [58+`PCS_DATA_W-1:0] line;
		blk_data_t                 dout;
		line = {{`PCS_DATA_W{1'b0}}, hist};
		for (int i = 0; i < `PCS_DATA_W; i++) begin
			dout[i]      = din[i] ^ line[i + 19] ^ line[i];   // line bits 39 and 58 back
			line[58 + i] = desc ? din[i] : dout[i];            // scrambled bit joins the line
		end
		hist = line[58+`PCS_DATA_W-1:`PCS_DATA_W];
		return dout;
	endfunction

	function automatic sync_head_t rand_head();
		return $urandom_range(1) ? HEAD_DATA : HEAD_CTRL;
	endfunction

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp) else begin
			$display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic report_problem(input string what);
		$display("ERROR at %0t ns: %s", $time, what);
		errors++;
	endtask

	// drive one block and check the block leaving the DUT in the same clock
	task automatic send_block(input bit valid, input sync_head_t head, input blk_data_t payload,
			input bit loop);
		blk_data_t got;
		@(posedge OSC_50m);
		#2;
		rx_valid_i = valid;
		rx_head_i  = head;
		rx_data_i  = '0;
		if (valid) begin
			rx_data_i = line_code(payload, tx_hist, 1'b0);
			exp_head_q.push_back(loop ? head : HEAD_CTRL);   // idle block when unlocked
			exp_data_q.push_back(loop ? payload : blk_data_t'(`PCS_IDLE_DATA));
			win_pos = (win_pos + 1) % `PCS_LOCK_WIN;
		end
		check_val("tx_valid_o", tx_valid_o, vld_pipe[1]);   // two cycle latency
		vld_pipe = {vld_pipe[0], valid};
		if (tx_valid_o === 1'b1) begin
			got = line_code(tx_data_o, out_hist, 1'b1);
			assert (exp_head_q.size() > 0) else report_problem("tx block nobody sent");
			if (exp_head_q.size() > 0) begin
				if (out_seen) begin   // first block resyncs the descrambler
					check_val("tx_head_o", tx_head_o, exp_head_q[0]);
					check_val("tx_data_o", got, exp_data_q[0]);
				end
				void'(exp_head_q.pop_front());
				void'(exp_data_q.pop_front());
			end
			out_seen = 1'b1;
		end
	endtask

	task automatic idle_cycle();
		send_block(1'b0, '0, '0, 1'b0);
	endtask

	task automatic flush();
		for (int n = 0; n < TIMEOUT && exp_head_q.size() > 0; n++)
			idle_cycle();
		assert (exp_head_q.size() == 0) else report_problem("expected tx blocks never came out");
	endtask

	task automatic pad_to_window();
		while (win_pos != 0)   // good blocks up to the next window start
			send_block(1'b1, rand_head(), {$urandom, $urandom}, 1'b1);
	endtask

	// fresh run of good headers; lock_start is the lock seen on the first step
	task automatic gain_lock(input bit lock_start);
		for (int k = 0; k <= `PCS_LOCK_GOOD + 1; k++) begin
			send_block(1'b1, rand_head(), {$urandom, $urandom}, k >= `PCS_LOCK_GOOD);
			// one cycle in the descrambler, one in the lock fsm
			check_val("block_lock_o", block_lock_o, (k == 0) ? lock_start : (k > `PCS_LOCK_GOOD));
		end
		check_val("link_ready_o", link_ready_o, 1'b1);
		win_pos = 2;   // two blocks of the first window already sent
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests++;
		if (errors != errs_before)
			failed++;
		$display("test %-10s %s", name, (errors == errs_before) ? "passed" : "failed");
	endtask

	task automatic reset_release_order();
		int e, n, t_ta, t_td, t_ra, t_lk, t_rd;
		e    = errors;
		t_ta = -1;
		t_td = -1;
		t_ra = -1;
		t_lk = -1;
		t_rd = -1;
		repeat (40) idle_cycle();   // calibration still running
		check_val("gx_tx_analogreset_o", gx_tx_analogreset_o, 1'b1);
		check_val("gx_tx_digitalreset_o", gx_tx_digitalreset_o, 1'b1);
		check_val("gx_rx_analogreset_o", gx_rx_analogreset_o, 1'b1);
		check_val("gx_rx_digitalreset_o", gx_rx_digitalreset_o, 1'b1);
		check_val("block_lock_o", block_lock_o, 1'b0);
		check_val("link_ready_o", link_ready_o, 1'b0);
		gx_tx_cal_busy_i = 1'b0;    // step 0 of the count
		gx_rx_cal_busy_i = 1'b0;
		for (n = 1; n < TIMEOUT && t_rd < 0; n++) begin
			idle_cycle();
			if (!gx_tx_analogreset_o && t_ta < 0)
				t_ta = n;
			if (!gx_tx_digitalreset_o && t_td < 0)
				t_td = n;
			if (!gx_rx_analogreset_o && t_ra < 0)
				t_ra = n;
			if (!gx_rx_digitalreset_o)
				t_rd = n;
			assert (t_rd < 0 || t_lk >= 0) else report_problem("rx ready before CDR lock");
			if (t_ra >= 0 && t_lk < 0 && n == t_ra + 5) begin   // cdr locks a bit later
				gx_rx_is_lockedtodata_i = 1'b1;
				t_lk = n;
			end
		end
		assert (t_rd >= 0) else report_problem("reset sequence never finished");
		// one edge to see each input, then the hold
		check_val("tx analog release cycle", t_ta, `PCS_RST_HOLD + 1);
		check_val("tx digital release cycle", t_td, t_ta + `PCS_RST_HOLD);
		check_val("rx analog release cycle", t_ra, t_td + `PCS_RST_HOLD);
		check_val("rx digital release cycle", t_rd, t_lk + `PCS_RST_HOLD + 1);
		finish_test("reset", e);
	endtask

	task automatic idle_before_lock();
		int e;
		e = errors;
		for (int k = 0; k < 40; k++)   // bad header every 7th block so no full run builds up
			send_block(1'b1, (k % 7 == 6 || k == 39) ? 2'b00 : rand_head(),
				{$urandom, $urandom}, 1'b0);
		check_val("block_lock_o", block_lock_o, 1'b0);
		finish_test("idle", e);
	endtask

	task automatic lock_acquisition();
		int e;
		e = errors;
		gain_lock(1'b0);
		finish_test("lock_gain", e);
	endtask

	task automatic payload_loopback();
		int e;
		e = errors;
		for (int k = 0; k < 100; k++) begin
			if ($urandom_range(3) == 0)
				idle_cycle();   // gap that the scrambler state must hold across
			send_block(1'b1, rand_head(), {$urandom, $urandom}, 1'b1);
		end
		check_val("block_lock_o", block_lock_o, 1'b1);
		finish_test("loopback", e);
	endtask

	task automatic lock_loss_window();
		int e;
		e = errors;
		pad_to_window();
		for (int k = 0; k < `PCS_LOCK_BAD; k++) begin
			send_block(1'b1, (k % 2) ? 2'b11 : 2'b00, {$urandom, $urandom}, 1'b1);
			check_val("block_lock_o", block_lock_o, 1'b1);
		end
		gain_lock(1'b1);   // falls on its second step and relocks after
		pad_to_window();
		for (int w = 0; w < 2; w++) begin   // two windows each one bad header short of the limit
			for (int k = 0; k < `PCS_LOCK_WIN; k++) begin
				send_block(1'b1, (k < `PCS_LOCK_BAD - 1) ? 2'b11 : rand_head(),
					{$urandom, $urandom}, 1'b1);
				check_val("block_lock_o", block_lock_o, 1'b1);
			end
		end
		flush();
		check_val("block_lock_o", block_lock_o, 1'b1);
		finish_test("lock_loss", e);
	endtask

	task automatic cdr_loss_reaction();
		int e;
		e = errors;
		flush();
		gx_rx_is_lockedtodata_i = 1'b0;
		for (int n = 0; n < TIMEOUT && !gx_rx_digitalreset_o; n++)
			idle_cycle();
		assert (gx_rx_digitalreset_o) else report_problem("rx digital reset stayed low on CDR loss");
		check_val("block_lock_o", block_lock_o, 1'b0);
		check_val("link_ready_o", link_ready_o, 1'b0);
		check_val("gx_tx_analogreset_o", gx_tx_analogreset_o, 1'b0);   // tx side untouched
		check_val("gx_tx_digitalreset_o", gx_tx_digitalreset_o, 1'b0);
		check_val("gx_rx_analogreset_o", gx_rx_analogreset_o, 1'b0);
		finish_test("cdr_loss", e);
	endtask

	initial begin
		void'($urandom(61125));
		OSC_50m                 = 1'b0;
		rst_n_i                 = 1'b0;
		gx_tx_cal_busy_i        = 1'b1;
		gx_rx_cal_busy_i        = 1'b1;
		gx_rx_is_lockedtodata_i = 1'b0;
		rx_valid_i              = 1'b0;
		rx_head_i               = '0;
		rx_data_i               = '0;
		tx_hist                 = 58'({$urandom, $urandom});   // any start state since the descrambler resyncs
		out_hist                = '0;
		vld_pipe                = '0;
		out_seen                = 1'b0;
		win_pos                 = 0;
		errors                  = 0;
		tests                   = 0;
		failed                  = 0;
		repeat (8) @(posedge OSC_50m);
		#2;
		rst_n_i = 1'b1;
		reset_release_order();
		idle_before_lock();
		lock_acquisition();
		payload_loopback();
		lock_loss_window();
		cdr_loss_reaction();
		assert (pcs_loopback_top_inst.pcs_loopback_sva_inst.fail_cnt == 0)
			else report_problem("bound concurrent assertions failed during the run");
		$display("tests run %0d, tests failed %0d, errors %0d", tests, failed, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule
